// ==== dv/pipe32_trace.txt ====
# I <byte address> <instruction word>, all hex
# R <rd> <value>, expected results in commit order, all hex
I 00000000 24401234
I 00000004 20445678
I 00000008 2080ffff
I 0000000c 04c48000
I 00000010 090c4000
I 00000014 15504000
I 00000018 21800004
I 0000001c 19c58000
I 00000020 1e158000
I 00000024 0e55c000
I 00000028 10224000
I 0000002c 06824000
I 00000030 28480003
I 00000034 2e680003
I 00000038 2a680003
I 0000003c 22c00111
I 00000040 22c00222
I 00000044 22ec0001
I 00000048 2ec00003
I 0000004c 23000333
I 00000050 23000444
I 00000054 232cfffe
I 00000058 07700000
R 1 12340000
R 1 12345678
R 2 ffffffff
R 3 12345677
R 4 ffffffff
R 5 edcba987
R 6 00000004
R 7 23456780
R 8 0edcba98
R 9 21412180
R 0 2fddbb98
R a 21412180
R b 00000001
R c ffffffff
R d ffffffff

// ==== pipe32.f ====
+incdir+logic
logic/pipe32_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/result_unit.sv
logic/pipe32_core.sv
dv/pipe32_properties.sv
dv/pipe32_tb.sv

// ==== Makefile ====
# Verilator build and run for the pipe32 core testbench

VERILATOR ?= verilator
TOP       ?= pipe32_tb
FILELIST  ?= pipe32.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Everything OK

SOURCES := $(wildcard logic/*.sv logic/*.svh dv/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/pipe32_tb.sv ====
// ==================================================
// Testbench for the pipe32 core
// Program image and expected results come from dv/pipe32_trace.txt
// Run from the project root so the trace path resolves
// Four passes, each after its own reset, with rising
// amounts of random imem_rdy and wb_ready activity
// ==================================================
`include "pipe32_settings.svh"

module pipe32_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RUN_LIMIT   = 3000;  // Cycles allowed per pass
    localparam int IDLE_CYCLES = 40;    // Quiet window after the last result

    logic                   clk;
    logic                   rst_n;
    logic                   imem_rdy;
    logic                   wb_ready;
    logic                   wb_valid;
    pipe32_pkg::addr_t      imem_addr;
    pipe32_pkg::insn_t      imem_data;
    pipe32_pkg::wb_result_t wb_result;

    pipe32_pkg::insn_t      imem [pipe32_pkg::addr_t];  // Sparse program image
    pipe32_pkg::wb_result_t expected [$];               // In commit order
    logic [31:0]            lfsr_state = 32'h3baa_ef5c;
    logic [1:0]             mode;  // Bit 0 randomizes imem_rdy and bit 1 wb_ready
    int                     exp_idx;
    int                     checks;
    int                     errors;
    int                     timeouts;

    pipe32_core u_pipe32_core (
        .clk, .rst_n,
        .imem_addr, .imem_data, .imem_rdy,
        .wb_valid, .wb_ready, .wb_result
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    task automatic load_trace();
        int                     fd;
        int                     n;
        byte                    kind;
        logic [31:0]            f1;
        logic [31:0]            f2;
        string                  line;
        pipe32_pkg::wb_result_t res;
        fd = $fopen("dv/pipe32_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open dv/pipe32_trace.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%c %h %h", kind, f1, f2);
            if (n == 3 && kind == "I") begin
                imem[f1] = f2;
            end else if (n == 3 && kind == "R") begin
                res.rd    = pipe32_pkg::reg_idx_t'(f1);
                res.value = f2;
                expected.push_back(res);
            end
        end
        $fclose(fd);
        if (expected.size() == 0) begin
            $display("The trace holds no expected results");
            errors++;
        end
    endtask

    task automatic check_result(input pipe32_pkg::wb_result_t got,
                                input pipe32_pkg::wb_result_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: result %0d is r%0d=%h, expected r%0d=%h",
                     $time, exp_idx, got.rd, got.value, exp.rd, exp.value);
        end
    endtask

    task automatic check_pc(input pipe32_pkg::addr_t got, input pipe32_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: imem_addr is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Drive inputs on the falling edge, then log a result that the next edge accepts
    task automatic step_cycle();
        @(negedge clk);
        imem_data = imem.exists(imem_addr) ? imem[imem_addr] : '0;  // NOP outside image
        imem_rdy  = mode[0] ? next_bit() : 1'b1;
        wb_ready  = mode[1] ? next_bit() : 1'b1;
        if (rst_n && wb_valid && wb_ready) begin
            if (exp_idx < expected.size()) begin
                check_result(wb_result, expected[exp_idx]);
            end else begin
                errors++;
                $display("Extra result r%0d=%h after the last expected one, at %0d ns",
                         wb_result.rd, wb_result.value, $time);
            end
            exp_idx++;
        end
    endtask

    task automatic run_pass(input logic [1:0] pass_mode);
        int cycles;
        mode  = pass_mode;
        rst_n = 1'b0;
        repeat (16) step_cycle();
        rst_n = 1'b1;
        check_pc(imem_addr, `PIPE32_RESET_PC);
        check_flag(wb_valid, 1'b0, "wb_valid after reset");
        exp_idx = 0;
        cycles  = 0;
        while (exp_idx < expected.size() && cycles < RUN_LIMIT) begin
            step_cycle();
            cycles++;
        end
        if (exp_idx < expected.size()) begin
            timeouts++;
            $display("Timeout in pass %0d: %0d of %0d results arrived in %0d cycles",
                     pass_mode, exp_idx, expected.size(), RUN_LIMIT);
        end else begin
            repeat (IDLE_CYCLES) step_cycle();  // Late or doubled results show up here
            check_flag(wb_valid, 1'b0, "wb_valid after the program");
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        imem_rdy  = 1'b0;
        wb_ready  = 1'b0;
        imem_data = '0;
        mode      = 2'b00;
        exp_idx   = 0;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        load_trace();
        for (int p = 0; p < 4; p++) begin
            run_pass(p[1:0]);  // Both ready first and random patterns after
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== dv/pipe32_properties.sv ====
// ==================================================
// Handshake and PC assertions, bound into pipe32_core
// All sampled on the rising clock edge
// ==================================================
module pipe32_properties (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   wb_valid,
    input logic                   wb_ready,
    input pipe32_pkg::wb_result_t wb_result,
    input pipe32_pkg::addr_t      imem_addr
);
    timeunit 1ns;
    timeprecision 100ps;

    // Refused result holds still until taken
    property result_held_p;
        @(posedge clk) disable iff (!rst_n)
            wb_valid && !wb_ready |=> wb_valid && $stable(wb_result);
    endproperty

    property pc_aligned_p;
        @(posedge clk) disable iff (!rst_n)
            imem_addr[1:0] == 2'b00;  // Word fetches only
    endproperty

    property quiet_in_reset_p;
        @(posedge clk) !rst_n |-> !wb_valid;
    endproperty

    result_held_a: assert property (result_held_p)
        else $error("wb_result or wb_valid changed while wb_ready was low");

    pc_aligned_a: assert property (pc_aligned_p)
        else $error("imem_addr %h is not word aligned", imem_addr);

    quiet_in_reset_a: assert property (quiet_in_reset_p)
        else $error("wb_valid high during reset");

endmodule

bind pipe32_core pipe32_properties u_pipe32_properties (
    .clk, .rst_n, .wb_valid, .wb_ready, .wb_result, .imem_addr
);

// ==== logic/pipe32_core.sv ====
// ================================================
// Four-stage in-order core: IF, ID, EX, WB
// Instruction port has no request, address is live
// Taken branch squashes two younger slots
// ================================================
module pipe32_core (
    input  logic                   clk,
    input  logic                   rst_n,
    output pipe32_pkg::addr_t      imem_addr,
    input  pipe32_pkg::insn_t      imem_data,
    input  logic                   imem_rdy,
    output logic                   wb_valid,
    input  logic                   wb_ready,
    output pipe32_pkg::wb_result_t wb_result
);

    pipe32_pkg::fetch_out_t fetch_out;
    pipe32_pkg::dec_out_t   dec_out;
    pipe32_pkg::exe_out_t   exe_out;
    pipe32_pkg::fwd_t       fwd_exe;
    pipe32_pkg::fwd_t       fwd_res;
    pipe32_pkg::addr_t      redirect_pc;
    pipe32_pkg::reg_idx_t   rs1;
    pipe32_pkg::reg_idx_t   rs2;
    pipe32_pkg::reg_idx_t   wr_idx;
    pipe32_pkg::word_t      rd1;
    pipe32_pkg::word_t      rd2;
    pipe32_pkg::word_t      wr_data;
    logic                   stall;
    logic                   redirect;
    logic                   wr_en;

    fetch_stage u_fetch (
        .clk, .rst_n,
        .imem_data, .imem_rdy, .stall, .redirect, .redirect_pc,
        .imem_addr, .fetch_out
    );

    reg_file u_reg_file (
        .clk, .rst_n,
        .rs1, .rs2, .wr_idx, .wr_en, .wr_data,
        .rd1, .rd2
    );

    decode_unit u_decode (
        .clk, .rst_n,
        .fetch_out, .stall, .redirect, .fwd_exe, .fwd_res, .rd1, .rd2,
        .rs1, .rs2, .dec_out
    );

    execute_unit u_execute (
        .clk, .rst_n,
        .dec_out, .stall,
        .fwd_exe, .redirect, .redirect_pc, .exe_out
    );

    result_unit u_result (
        .clk, .rst_n,
        .exe_out, .wb_ready,
        .wb_valid, .stall, .wr_en, .wb_result, .wr_idx, .wr_data, .fwd_res
    );

endmodule

// ==== logic/result_unit.sv ====
// ================================================
// One-entry result buffer on a valid/ready port
// Commit to reg file happens on the accept edge
// Refused result stalls every earlier stage
// ================================================
module result_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pipe32_pkg::exe_out_t   exe_out,
    input  logic                   wb_ready,
    output logic                   wb_valid,
    output logic                   stall,
    output logic                   wr_en,
    output pipe32_pkg::wb_result_t wb_result,
    output pipe32_pkg::reg_idx_t   wr_idx,
    output pipe32_pkg::word_t      wr_data,
    output pipe32_pkg::fwd_t       fwd_res
);

    pipe32_pkg::exe_out_t hold_q;

    // Refill whenever empty or being accepted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_q.valid <= 1'b0;
        end else if (!stall) begin
            hold_q <= exe_out;
        end
    end

    assign wb_valid  = hold_q.valid;
    assign wb_result = '{rd: hold_q.rd, value: hold_q.value};
    assign stall     = hold_q.valid && !wb_ready;

    assign wr_en   = hold_q.valid && wb_ready;  // Accept edge
    assign wr_idx  = hold_q.rd;
    assign wr_data = hold_q.value;

    // Not yet in the reg file until accepted
    assign fwd_res = '{valid: hold_q.valid, rd: hold_q.rd, value: hold_q.value};

endmodule

// ==== logic/execute_unit.sv ====
// ================================================
// ALU, branch compare and execute-to-result path
// Shifts are logical, amount from b[4:0]
// Redirect fires once per branch, even in a stall
// ================================================
module execute_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pipe32_pkg::dec_out_t dec_out,
    input  logic                 stall,
    output pipe32_pkg::fwd_t     fwd_exe,
    output logic                 redirect,
    output pipe32_pkg::addr_t    redirect_pc,
    output pipe32_pkg::exe_out_t exe_out
);

    pipe32_pkg::word_t alu_res;
    logic [4:0]        shamt;
    logic              taken;
    logic              redirect_done;  // Held branch already redirected

    assign shamt = dec_out.b[4:0];

    always_comb begin
        case (dec_out.alu_op)
            pipe32_pkg::ALU_ADD:    alu_res = dec_out.a + dec_out.b;
            pipe32_pkg::ALU_SUB:    alu_res = dec_out.a - dec_out.b;
            pipe32_pkg::ALU_AND:    alu_res = dec_out.a & dec_out.b;
            pipe32_pkg::ALU_OR:     alu_res = dec_out.a | dec_out.b;
            pipe32_pkg::ALU_XOR:    alu_res = dec_out.a ^ dec_out.b;
            pipe32_pkg::ALU_SHL:    alu_res = dec_out.a << shamt;
            pipe32_pkg::ALU_SHR:    alu_res = dec_out.a >> shamt;
            default:                alu_res = dec_out.b;  // LUI pass-through
        endcase
    end

    // Branch resolution
    always_comb begin
        case (dec_out.br)
            pipe32_pkg::BR_EQ: taken = dec_out.valid && (dec_out.a == dec_out.b);
            pipe32_pkg::BR_NE: taken = dec_out.valid && (dec_out.a != dec_out.b);
            default:           taken = 1'b0;
        endcase
    end

    assign redirect    = taken && !redirect_done;
    assign redirect_pc = dec_out.br_target;

    // A stalled branch stays in ID/EX, remember it fired
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_done <= 1'b0;
        end else begin
            redirect_done <= stall && (redirect_done || redirect);
        end
    end

    // Only writing instructions carry a result
    assign exe_out.valid = dec_out.valid && dec_out.we;
    assign exe_out.rd    = dec_out.rd;
    assign exe_out.value = alu_res;

    assign fwd_exe = '{valid: exe_out.valid, rd: dec_out.rd, value: alu_res};

endmodule

// ==== logic/decode_unit.sv ====
// ================================================
// Field decode, operand forwarding, ID/EX register
// Forward priority is execute, result, reg file
// Branch second operand is read from the rd field
// ================================================
`include "pipe32_settings.svh"

module decode_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pipe32_pkg::fetch_out_t fetch_out,
    input  logic                   stall,
    input  logic                   redirect,
    input  pipe32_pkg::fwd_t       fwd_exe,
    input  pipe32_pkg::fwd_t       fwd_res,
    input  pipe32_pkg::word_t      rd1,
    input  pipe32_pkg::word_t      rd2,
    output pipe32_pkg::reg_idx_t   rs1,
    output pipe32_pkg::reg_idx_t   rs2,
    output pipe32_pkg::dec_out_t   dec_out
);

    localparam int OP_W = $bits(pipe32_pkg::opcode_e);

    pipe32_pkg::opcode_e     op;
    pipe32_pkg::reg_idx_t    rd_f;
    logic [`PIPE32_IMM_W-1:0] imm;
    pipe32_pkg::word_t       imm_sext;
    pipe32_pkg::word_t       opnd_a;
    pipe32_pkg::word_t       opnd_b;
    logic                    is_branch;
    pipe32_pkg::dec_out_t    dec_next;

    // Newest producer wins and r0 is never forwarded
    function automatic pipe32_pkg::word_t fwd_pick(
        input pipe32_pkg::reg_idx_t idx,
        input pipe32_pkg::word_t    rf_val,
        input pipe32_pkg::fwd_t     fe,
        input pipe32_pkg::fwd_t     fr
    );
        if (idx == '0) return '0;
        if (fe.valid && fe.rd == idx) return fe.value;
        if (fr.valid && fr.rd == idx) return fr.value;
        return rf_val;
    endfunction

    assign op        = pipe32_pkg::opcode_e'(fetch_out.insn[`PIPE32_OP_MSB -: OP_W]);
    assign rd_f      = fetch_out.insn[`PIPE32_RD_LSB +: $bits(pipe32_pkg::reg_idx_t)];
    assign imm       = fetch_out.insn[`PIPE32_IMM_W-1:0];
    assign imm_sext  = {{(32-`PIPE32_IMM_W){imm[`PIPE32_IMM_W-1]}}, imm};
    assign is_branch = (op == pipe32_pkg::OP_BEQ) || (op == pipe32_pkg::OP_BNE);

    assign rs1 = fetch_out.insn[`PIPE32_RS1_LSB +: $bits(pipe32_pkg::reg_idx_t)];
    assign rs2 = is_branch ? rd_f  // rs2 bits overlap the offset
                           : fetch_out.insn[`PIPE32_RS2_LSB +: $bits(pipe32_pkg::reg_idx_t)];

    assign opnd_a = fwd_pick(rs1, rd1, fwd_exe, fwd_res);
    assign opnd_b = fwd_pick(rs2, rd2, fwd_exe, fwd_res);

    always_comb begin
        dec_next           = '0;
        dec_next.valid     = fetch_out.valid && !redirect;  // Squash behind taken branch
        dec_next.pc        = fetch_out.pc;
        dec_next.a         = opnd_a;
        dec_next.b         = opnd_b;
        dec_next.rd        = rd_f;
        dec_next.br_target = fetch_out.pc + (imm_sext << 2);  // Word offset
        dec_next.alu_op    = pipe32_pkg::ALU_ADD;
        dec_next.br        = pipe32_pkg::BR_NONE;
        dec_next.we        = 1'b1;  // Writes rd unless cleared below
        case (op)
            pipe32_pkg::OP_ADD:  dec_next.alu_op = pipe32_pkg::ALU_ADD;
            pipe32_pkg::OP_SUB:  dec_next.alu_op = pipe32_pkg::ALU_SUB;
            pipe32_pkg::OP_AND:  dec_next.alu_op = pipe32_pkg::ALU_AND;
            pipe32_pkg::OP_OR:   dec_next.alu_op = pipe32_pkg::ALU_OR;
            pipe32_pkg::OP_XOR:  dec_next.alu_op = pipe32_pkg::ALU_XOR;
            pipe32_pkg::OP_SHL:  dec_next.alu_op = pipe32_pkg::ALU_SHL;
            pipe32_pkg::OP_SHR:  dec_next.alu_op = pipe32_pkg::ALU_SHR;
            pipe32_pkg::OP_ADDI: dec_next.b      = imm_sext;
            pipe32_pkg::OP_LUI: begin
                dec_next.alu_op = pipe32_pkg::ALU_PASS_B;
                dec_next.b      = {imm, {(32-`PIPE32_IMM_W){1'b0}}};
            end
            pipe32_pkg::OP_BEQ: begin
                dec_next.br = pipe32_pkg::BR_EQ;
                dec_next.we = 1'b0;
            end
            pipe32_pkg::OP_BNE: begin
                dec_next.br = pipe32_pkg::BR_NE;
                dec_next.we = 1'b0;
            end
            default:            dec_next.we = 1'b0;  // NOP and unknown codes
        endcase
    end

    // ID/EX register holds while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_out.valid <= 1'b0;
        end else if (!stall) begin
            dec_out <= dec_next;
        end
    end

endmodule

// ==== logic/reg_file.sv ====
// ================================================
// 2R1W register file, asynchronous reads
// r0 ignores writes and reads as zero
// Same-edge write is not visible to reads
// ================================================
`include "pipe32_settings.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pipe32_pkg::reg_idx_t rs1,
    input  pipe32_pkg::reg_idx_t rs2,
    input  pipe32_pkg::reg_idx_t wr_idx,
    input  logic                 wr_en,
    input  pipe32_pkg::word_t    wr_data,
    output pipe32_pkg::word_t    rd1,
    output pipe32_pkg::word_t    rd2
);

    pipe32_pkg::word_t regs [`PIPE32_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PIPE32_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin  // r0 stays zero
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

// ==== logic/fetch_stage.sv ====
// ================================================
// PC and fetch/decode register
// imem_data is sampled only on edges with imem_rdy
// Redirect wins over stall and bubbles
// ================================================
`include "pipe32_settings.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pipe32_pkg::insn_t      imem_data,
    input  logic                   imem_rdy,
    input  logic                   stall,
    input  logic                   redirect,
    input  pipe32_pkg::addr_t      redirect_pc,
    output pipe32_pkg::addr_t      imem_addr,
    output pipe32_pkg::fetch_out_t fetch_out
);

    pipe32_pkg::addr_t pc_q;  // Address being fetched
    logic              take;  // Instruction accepted this edge

    assign imem_addr = pc_q;
    assign take      = imem_rdy && !stall && !redirect;

    // Program counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `PIPE32_RESET_PC;
        end else if (redirect) begin
            pc_q <= redirect_pc;  // Taken branch target
        end else if (take) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // Fetch/decode register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_out.valid <= 1'b0;
        end else begin
            if (redirect) begin
                fetch_out.valid <= 1'b0;  // Younger slot squashed
            end else if (!stall) begin
                fetch_out.valid <= imem_rdy;  // Bubble when memory not ready
            end
            if (take) begin
                fetch_out.pc   <= pc_q;  // Payload moves only with an accepted instruction
                fetch_out.insn <= imem_data;
            end
        end
    end

endmodule

// ==== logic/pipe32_pkg.sv ====
// ================================================
// Types shared by all pipeline stages
// Opcode values are the encoding the program uses
// Branches compare reg[rs1] with reg[rd]
// ================================================
`include "pipe32_settings.svh"

package pipe32_pkg;

    typedef logic [31:0] word_t;  // Data word
    typedef logic [31:0] addr_t;  // Byte address
    typedef logic [31:0] insn_t;  // Raw instruction
    typedef logic [$clog2(`PIPE32_NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [5:0] {
        OP_NOP  = 6'h00,
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        OP_SHL  = 6'h06,
        OP_SHR  = 6'h07,
        OP_ADDI = 6'h08,  // rd = rs1 + sext(imm)
        OP_LUI  = 6'h09,  // rd = imm << 16
        OP_BEQ  = 6'h0a,
        OP_BNE  = 6'h0b
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} br_kind_e;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        insn_t insn;
    } fetch_out_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        alu_op_e  alu_op;
        word_t    a;
        word_t    b;
        br_kind_e br;
        addr_t    br_target;
        logic     we;         // Writes rd
        reg_idx_t rd;
    } dec_out_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
    } exe_out_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    value;
    } wb_result_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
    } fwd_t;

endpackage

// ==== logic/pipe32_settings.svh ====
// ================================================
// Core-wide constants, shared by package and RTL
// Instruction fields assume a fixed 32-bit format
// Register count must be a power of two
// ================================================
`ifndef PIPE32_SETTINGS_SVH
`define PIPE32_SETTINGS_SVH

// PC after reset, fetch steps by 4 from here
`define PIPE32_RESET_PC 32'h0000_0000

// Register file depth, r0 is hardwired to zero
`define PIPE32_NUM_REGS 16

// Field positions
`define PIPE32_OP_MSB   31  // Opcode in [31:26]
`define PIPE32_RD_LSB   22  // Rd in [25:22]
`define PIPE32_RS1_LSB  18  // Rs1 in [21:18]
`define PIPE32_RS2_LSB  14  // Rs2 in [17:14]
`define PIPE32_IMM_W    16  // Immediate in [15:0]

`endif
